// File: include/host_chan_settings.svh
/*
 * Build-time sizing for the host channel concentrator.
 * Included by the package and by every module that needs a width or a count.
 */

`ifndef HOST_CHAN_SETTINGS_SVH
`define HOST_CHAN_SETTINGS_SVH

// Number of virtual functions sharing the physical TLP stream pair
`define NUM_PORTS 4

// Width of the function number carried in each TLP header
`define FUNC_W 2

// Word address width and data word width of one TLP
`define ADDR_W 8
`define DATA_W 32

// Words held by the host memory completer
`define MEM_DEPTH 256

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the host channel concentrator testbench with Verilator.
# The run counts as passed only if the log holds the pass message.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_host_chan -o sim_host_chan

./obj_dir/sim_host_chan | tee sim.log

if grep -qF "*** PASSED ***" sim.log
then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail, see sim.log"
    exit 1
fi

// File: sim/tb_host_chan.sv
/*
 * Self-checking testbench for the host channel concentrator.
 * Every function issues random reads and writes on TX A and TX B, and a
 * monitor checks each RX beat against a shadow memory and a tag table.
 */

`include "host_chan_settings.svh"

module tb_host_chan
    import host_chan_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS      = `NUM_PORTS;
    localparam int FUNC_W         = `FUNC_W;
    localparam int ADDR_W         = `ADDR_W;
    localparam int DATA_W         = `DATA_W;
    localparam int MEM_DEPTH      = `MEM_DEPTH;
    localparam int NUM_REQ        = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 40 + 2000;
    // Quiet cycles after reset, used to check that no response appears early
    localparam int IDLE_CYCLES    = 20;

    logic                             clk;
    logic                             rst_n;
    logic [NUM_PORTS-1:0]             tx_a_valid;
    logic [NUM_PORTS-1:0]             tx_a_ready;
    tlp_hdr_t [NUM_PORTS-1:0]         tx_a_hdr;
    logic [NUM_PORTS-1:0][DATA_W-1:0] tx_a_data;
    logic [NUM_PORTS-1:0]             tx_b_valid;
    logic [NUM_PORTS-1:0]             tx_b_ready;
    tlp_hdr_t [NUM_PORTS-1:0]         tx_b_hdr;
    logic [NUM_PORTS-1:0][DATA_W-1:0] tx_b_data;
    logic [NUM_PORTS-1:0]             rx_a_valid;
    logic [NUM_PORTS-1:0]             rx_a_ready;
    tlp_hdr_t [NUM_PORTS-1:0]         rx_a_hdr;
    logic [NUM_PORTS-1:0][DATA_W-1:0] rx_a_data;
    logic [NUM_PORTS-1:0]             rx_b_valid;
    logic [NUM_PORTS-1:0]             rx_b_ready;
    tlp_hdr_t [NUM_PORTS-1:0]         rx_b_hdr;
    logic [NUM_PORTS-1:0][DATA_W-1:0] rx_b_data;

    // TX beats seen with valid and ready at the falling edge, so they
    // transfer on the next rising edge
    logic [NUM_PORTS-1:0]             tx_a_fire;
    logic [NUM_PORTS-1:0]             tx_b_fire;

    // Shadow of host memory, written when a write is issued
    logic [DATA_W-1:0]                shadow [MEM_DEPTH];
    // An address with a request in flight is not touched again until it completes
    bit                               addr_busy [MEM_DEPTH];

    // Outstanding requests per function, indexed by tag
    bit                               pend_valid [NUM_PORTS][256];
    tlp_hdr_t                         exp_hdr [NUM_PORTS][256];
    logic [DATA_W-1:0]                exp_data [NUM_PORTS][256];
    logic [7:0]                       tag_next [NUM_PORTS];

    integer                           seed;
    int                               issued_total;
    int                               resp_total;
    int                               mismatch_count;
    int                               other_count;
    int                               cycle_count;

    host_chan_mux_top UUT
    (
        .clk,
        .rst_n,
        .tx_a_valid,
        .tx_a_ready,
        .tx_a_hdr,
        .tx_a_data,
        .tx_b_valid,
        .tx_b_ready,
        .tx_b_hdr,
        .tx_b_data,
        .rx_a_valid,
        .rx_a_ready,
        .rx_a_hdr,
        .rx_a_data,
        .rx_b_valid,
        .rx_b_ready,
        .rx_b_hdr,
        .rx_b_data
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Expected read data is whatever was last written, zero after the sweep
    function automatic logic [DATA_W-1:0] ref_read_data(input logic [ADDR_W-1:0] addr);
        return shadow[addr];
    endfunction

    task automatic compare_hdr(input string name, input tlp_hdr_t exp, input tlp_hdr_t act);
        if (exp !== act)
        begin
            mismatch_count++;
            $display("MISMATCH at %0d ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_data(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        if (exp !== act)
        begin
            mismatch_count++;
            $display("MISMATCH at %0d ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // Builds one random request for function f and records its expected response.
    // Addresses carry the function number in the low bits, so functions never share one
    task automatic make_request(input int f, output tlp_hdr_t hdr,
                                output logic [DATA_W-1:0] data, output bit ok);
        logic [ADDR_W-1:0] addr;
        logic [7:0]        tag;
        bit                is_wr;
        addr = ADDR_W'($random(seed));
        addr[FUNC_W-1:0] = FUNC_W'(f);
        is_wr = bit'($random(seed));
        data = DATA_W'($random(seed));
        hdr = '0;
        ok = 1'b0;
        if (!addr_busy[addr])
        begin
            tag = tag_next[f];
            tag_next[f] = tag_next[f] + 8'd1;
            hdr.op   = is_wr ? OP_MEM_WR : OP_MEM_RD;
            // Junk func on purpose, the mux must replace it with the port number
            hdr.func = FUNC_W'($random(seed));
            hdr.tag  = tag;
            hdr.addr = addr;
            exp_hdr[f][tag].op   = is_wr ? OP_CPL : OP_CPL_D;
            exp_hdr[f][tag].func = FUNC_W'(f);
            exp_hdr[f][tag].tag  = tag;
            exp_hdr[f][tag].addr = addr;
            if (is_wr)
            begin
                shadow[addr] = data;
                // A commit carries no payload
                exp_data[f][tag] = '0;
            end
            else
            begin
                exp_data[f][tag] = ref_read_data(addr);
            end
            pend_valid[f][tag] = 1'b1;
            addr_busy[addr] = 1'b1;
            issued_total++;
            ok = 1'b1;
        end
    endtask

    // Matches one RX beat against the outstanding request with the same tag
    task automatic check_response(input int f, input bit is_b, input tlp_hdr_t act_hdr,
                                  input logic [DATA_W-1:0] act_data);
        logic [7:0] tag;
        string      side;
        tag = act_hdr.tag;
        side = is_b ? "b" : "a";
        if (!pend_valid[f][tag])
        begin
            other_count++;
            $display("ERROR at %0d ns: response with tag %0d on rx_%s port %0d has no request",
                     $time, tag, side, f);
        end
        else
        begin
            compare_hdr($sformatf("rx_%s_hdr[%0d]", side, f), exp_hdr[f][tag], act_hdr);
            compare_data($sformatf("rx_%s_data[%0d]", side, f), exp_data[f][tag], act_data);
            pend_valid[f][tag] = 1'b0;
            addr_busy[exp_hdr[f][tag].addr] = 1'b0;
            resp_total++;
        end
    endtask

    // Falling-edge monitor, all inputs and outputs are settled here
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            tx_a_fire = '0;
            tx_b_fire = '0;
        end
        else
        begin
            tx_a_fire = tx_a_valid & tx_a_ready;
            tx_b_fire = tx_b_valid & tx_b_ready;
            if (issued_total == 0 && (rx_a_valid != '0 || rx_b_valid != '0))
            begin
                other_count++;
                $display("ERROR at %0d ns: RX valid raised before any request", $time);
            end
            for (int f = 0; f < NUM_PORTS; f++)
            begin
                if (rx_a_valid[f] && rx_a_ready[f])
                    check_response(f, 1'b0, rx_a_hdr[f], rx_a_data[f]);
                if (rx_b_valid[f] && rx_b_ready[f])
                    check_response(f, 1'b1, rx_b_hdr[f], rx_b_data[f]);
            end
        end
    end

    // Run limit, in case a response never arrives
    initial
    begin
        int missing;
        cycle_count = 0;
        missing = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        for (int f = 0; f < NUM_PORTS; f++)
        begin
            for (int t = 0; t < 256; t++)
            begin
                if (pend_valid[f][t])
                    missing++;
            end
        end
        other_count++;
        $display("TIMEOUT after %0d cycles: %0d of %0d responses received",
                 cycle_count, resp_total, NUM_REQ);
        if (missing != 0)
            $display("ERROR: %0d issued requests still have no response", missing);
        $display("Summary: %0d requests, %0d responses, %0d mismatches, %0d other errors",
                 issued_total, resp_total, mismatch_count, other_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        tlp_hdr_t          hdr;
        logic [DATA_W-1:0] data;
        bit                ok;
        seed = 32'h548b56a4;
        issued_total = 0;
        resp_total = 0;
        mismatch_count = 0;
        other_count = 0;
        rst_n = 1'b0;
        tx_a_valid = '0;
        tx_a_hdr = '0;
        tx_a_data = '0;
        tx_b_valid = '0;
        tx_b_hdr = '0;
        tx_b_data = '0;
        rx_a_ready = '1;
        rx_b_ready = '1;
        tx_a_fire = '0;
        tx_b_fire = '0;
        for (int a = 0; a < MEM_DEPTH; a++)
        begin
            shadow[a] = '0;
            addr_busy[a] = 1'b0;
        end
        for (int f = 0; f < NUM_PORTS; f++)
        begin
            tag_next[f] = 8'd0;
            for (int t = 0; t < 256; t++)
                pend_valid[f][t] = 1'b0;
        end

        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);

        // Random traffic on every function, both streams at once
        while (resp_total < NUM_REQ)
        begin
            @(posedge clk);
            #10;
            for (int f = 0; f < NUM_PORTS; f++)
            begin
                if (tx_a_fire[f])
                    tx_a_valid[f] = 1'b0;
                if (tx_b_fire[f])
                    tx_b_valid[f] = 1'b0;
                if (!tx_a_valid[f] && issued_total < NUM_REQ && ($random(seed) & 3) != 0)
                begin
                    make_request(f, hdr, data, ok);
                    if (ok)
                    begin
                        tx_a_hdr[f] = hdr;
                        tx_a_data[f] = data;
                        tx_a_valid[f] = 1'b1;
                    end
                end
                if (!tx_b_valid[f] && issued_total < NUM_REQ && ($random(seed) & 3) != 0)
                begin
                    make_request(f, hdr, data, ok);
                    if (ok)
                    begin
                        tx_b_hdr[f] = hdr;
                        tx_b_data[f] = data;
                        tx_b_valid[f] = 1'b1;
                    end
                end
            end
            // Second half of the run throttles the RX side at random
            if (issued_total >= NUM_REQ / 2)
            begin
                rx_a_ready = NUM_PORTS'($random(seed) | $random(seed));
                rx_b_ready = NUM_PORTS'($random(seed) | $random(seed));
            end
        end

        // Drain with RX open, so a duplicate response would still show up
        rx_a_ready = '1;
        rx_b_ready = '1;
        repeat (50) @(posedge clk);

        $display("Summary: %0d requests, %0d responses, %0d mismatches, %0d other errors",
                 issued_total, resp_total, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
src/host_chan_pkg.sv
src/tlp_stream_if.sv
src/pf_vf_mux.sv
src/tlp_ab_arbiter.sv
src/local_commit.sv
src/host_mem_completer.sv
src/host_chan_mux_top.sv
sim/tb_host_chan.sv

// File: src/host_chan_mux_top.sv
/*
 * Host channel concentrator top level. Function TX A/B and RX A/B streams
 * come in as packed per-function ports and are reduced to a single TLP
 * path into the host memory completer. Commits return on RX B, read data on RX A.
 */

`include "host_chan_settings.svh"

module host_chan_mux_top
    import host_chan_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,

    // Function TX A
    input  logic [`NUM_PORTS-1:0]              tx_a_valid,
    output logic [`NUM_PORTS-1:0]              tx_a_ready,
    input  tlp_hdr_t [`NUM_PORTS-1:0]          tx_a_hdr,
    input  logic [`NUM_PORTS-1:0][`DATA_W-1:0] tx_a_data,

    // Function TX B
    input  logic [`NUM_PORTS-1:0]              tx_b_valid,
    output logic [`NUM_PORTS-1:0]              tx_b_ready,
    input  tlp_hdr_t [`NUM_PORTS-1:0]          tx_b_hdr,
    input  logic [`NUM_PORTS-1:0][`DATA_W-1:0] tx_b_data,

    // Function RX A, read data completions
    output logic [`NUM_PORTS-1:0]              rx_a_valid,
    input  logic [`NUM_PORTS-1:0]              rx_a_ready,
    output tlp_hdr_t [`NUM_PORTS-1:0]          rx_a_hdr,
    output logic [`NUM_PORTS-1:0][`DATA_W-1:0] rx_a_data,

    // Function RX B, write commits
    output logic [`NUM_PORTS-1:0]              rx_b_valid,
    input  logic [`NUM_PORTS-1:0]              rx_b_ready,
    output tlp_hdr_t [`NUM_PORTS-1:0]          rx_b_hdr,
    output logic [`NUM_PORTS-1:0][`DATA_W-1:0] rx_b_data
);

    localparam int NUM_PORTS = `NUM_PORTS;

    tlp_stream_if fn_tx_a [NUM_PORTS] ();
    tlp_stream_if fn_tx_b [NUM_PORTS] ();
    tlp_stream_if fn_rx_a [NUM_PORTS] ();
    tlp_stream_if fn_rx_b [NUM_PORTS] ();

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_fn
        assign fn_tx_a[p].valid = tx_a_valid[p];
        assign fn_tx_a[p].hdr   = tx_a_hdr[p];
        assign fn_tx_a[p].data  = tx_a_data[p];
        assign tx_a_ready[p]    = fn_tx_a[p].ready;

        assign fn_tx_b[p].valid = tx_b_valid[p];
        assign fn_tx_b[p].hdr   = tx_b_hdr[p];
        assign fn_tx_b[p].data  = tx_b_data[p];
        assign tx_b_ready[p]    = fn_tx_b[p].ready;

        assign rx_a_valid[p]    = fn_rx_a[p].valid;
        assign rx_a_hdr[p]      = fn_rx_a[p].hdr;
        assign rx_a_data[p]     = fn_rx_a[p].data;
        assign fn_rx_a[p].ready = rx_a_ready[p];

        assign rx_b_valid[p]    = fn_rx_b[p].valid;
        assign rx_b_hdr[p]      = fn_rx_b[p].hdr;
        assign rx_b_data[p]     = fn_rx_b[p].data;
        assign fn_rx_b[p].ready = rx_b_ready[p];
    end

    // Host-side streams between the blocks
    tlp_stream_if host_tx_a ();
    tlp_stream_if host_tx_b ();
    tlp_stream_if arb_tx ();
    tlp_stream_if req ();
    tlp_stream_if commit ();
    tlp_stream_if cpl ();

    // Mux A returns read completions, mux B returns write commits
    pf_vf_mux #(.N(NUM_PORTS)) mux_a
    (
        .clk,
        .rst_n,
        .fn_tx(fn_tx_a),
        .fn_rx(fn_rx_a),
        .host_tx(host_tx_a),
        .host_rx(cpl)
    );

    pf_vf_mux #(.N(NUM_PORTS)) mux_b
    (
        .clk,
        .rst_n,
        .fn_tx(fn_tx_b),
        .fn_rx(fn_rx_b),
        .host_tx(host_tx_b),
        .host_rx(commit)
    );

    tlp_ab_arbiter tx_ab_arb
    (
        .clk,
        .rst_n,
        .in_a(host_tx_a),
        .in_b(host_tx_b),
        .out(arb_tx)
    );

    // Commits are generated after A/B merge so each write is seen once
    local_commit commit_gen
    (
        .clk,
        .rst_n,
        .sink(arb_tx),
        .req(req),
        .commit(commit)
    );

    host_mem_completer mem_cpl
    (
        .clk,
        .rst_n,
        .req(req),
        .cpl(cpl)
    );

endmodule

// File: src/host_chan_pkg.sv
/*
 * Shared TLP types for the host channel concentrator.
 * Modules take the opcode enum and the header struct by a wildcard import.
 */

`include "host_chan_settings.svh"

package host_chan_pkg;

    // Request and completion opcodes carried in the header
    typedef enum logic [1:0]
    {
        OP_MEM_RD = 2'd0,
        OP_MEM_WR = 2'd1,
        // Write commit, carries no data
        OP_CPL    = 2'd2,
        // Read completion with data
        OP_CPL_D  = 2'd3
    } tlp_op_e;

    // One TLP header, sent alongside a single data word
    typedef struct packed
    {
        tlp_op_e               op;
        // Originating function on TX, destination function on RX
        logic [`FUNC_W-1:0]    func;
        // Matches a response to its request
        logic [7:0]            tag;
        // Word address in host memory
        logic [`ADDR_W-1:0]    addr;
    } tlp_hdr_t;

endpackage

// File: src/host_mem_completer.sv
/*
 * Host memory model standing in for the emulated device.
 * Writes are stored on acceptance, reads return one data completion.
 * The memory is swept to zero after reset before requests are taken.
 */

`include "host_chan_settings.svh"

module host_mem_completer
    import host_chan_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    tlp_stream_if.sink   req,
    tlp_stream_if.source cpl
);

    localparam int CLR_W = (`MEM_DEPTH > 1) ? $clog2(`MEM_DEPTH) : 1;

    typedef enum logic [1:0]
    {
        ST_CLEAR,
        ST_IDLE,
        ST_RESP
    } state_e;

    state_e             state;
    logic [CLR_W-1:0]   clear_addr;
    logic [`DATA_W-1:0] mem [`MEM_DEPTH];
    logic               req_xfer;
    logic               rd_xfer;
    logic               wr_xfer;
    tlp_hdr_t           cpl_hdr;
    logic [`DATA_W-1:0] cpl_data;

    // Requests are only taken while idle, so a pending completion stalls them
    assign req.ready = (state == ST_IDLE);
    assign req_xfer  = req.valid && req.ready;
    assign rd_xfer   = req_xfer && (req.hdr.op == OP_MEM_RD);
    assign wr_xfer   = req_xfer && (req.hdr.op == OP_MEM_WR);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= ST_CLEAR;
            clear_addr <= '0;
        end
        else
        begin
            case (state)
                ST_CLEAR:
                begin
                    clear_addr <= clear_addr + 1'b1;
                    if (clear_addr == CLR_W'(`MEM_DEPTH - 1))
                        state <= ST_IDLE;
                end
                ST_IDLE:
                begin
                    if (rd_xfer)
                        state <= ST_RESP;
                end
                default:
                begin
                    // Hold the completion until RX A accepts it
                    if (cpl.ready)
                        state <= ST_IDLE;
                end
            endcase
        end
    end

    // One write port, shared by the clearing sweep and by write requests
    always_ff @(posedge clk)
    begin
        if (state == ST_CLEAR)
            mem[clear_addr] <= '0;
        else if (wr_xfer)
            mem[req.hdr.addr] <= req.data;
    end

    always_ff @(posedge clk)
    begin
        if (rd_xfer)
        begin
            cpl_hdr.op   <= OP_CPL_D;
            cpl_hdr.func <= req.hdr.func;
            cpl_hdr.tag  <= req.hdr.tag;
            cpl_hdr.addr <= req.hdr.addr;
            cpl_data     <= mem[req.hdr.addr];
        end
    end

    assign cpl.valid = (state == ST_RESP);
    assign cpl.hdr   = cpl_hdr;
    assign cpl.data  = cpl_data;

endmodule

// File: src/local_commit.sv
/*
 * Local write commit generator, placed after A/B arbitration.
 * Requests pass straight through to the completer; every memory write
 * also produces one commit TLP, which travels back on RX B.
 */

`include "host_chan_settings.svh"

module local_commit
    import host_chan_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    tlp_stream_if.sink   sink,
    tlp_stream_if.source req,
    tlp_stream_if.source commit
);

    logic     is_wr;
    logic     pass_ok;
    logic     wr_xfer;
    logic     commit_valid;
    tlp_hdr_t commit_hdr;

    assign is_wr = (sink.hdr.op == OP_MEM_WR);

    // A write may only go through once there is room for its commit
    assign pass_ok = !is_wr || !commit_valid;

    assign req.valid  = sink.valid && pass_ok;
    assign req.hdr    = sink.hdr;
    assign req.data   = sink.data;
    assign sink.ready = req.ready && pass_ok;

    assign wr_xfer = sink.valid && sink.ready && is_wr;

    // The commit register fills on the write's transfer cycle and
    // holds until RX B takes it
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            commit_valid <= 1'b0;
        end
        else if (wr_xfer)
        begin
            commit_valid <= 1'b1;
        end
        else if (commit.ready)
        begin
            commit_valid <= 1'b0;
        end
    end

    // Commit echoes the request's routing fields
    always_ff @(posedge clk)
    begin
        if (wr_xfer)
        begin
            commit_hdr.op   <= OP_CPL;
            commit_hdr.func <= sink.hdr.func;
            commit_hdr.tag  <= sink.hdr.tag;
            commit_hdr.addr <= sink.hdr.addr;
        end
    end

    assign commit.valid = commit_valid;
    assign commit.hdr   = commit_hdr;
    // Commits carry no payload
    assign commit.data  = '0;

endmodule

// File: src/pf_vf_mux.sv
/*
 * PF/VF mux for one stream pair. Function TX beats are merged round-robin
 * into one registered host TX stream, tagged with the port index in func.
 * Host RX beats are routed back combinationally by the func field.
 */

`include "host_chan_settings.svh"

module pf_vf_mux
    import host_chan_pkg::*;
#(
    parameter int N = `NUM_PORTS
)
(
    input  logic         clk,
    input  logic         rst_n,
    tlp_stream_if.sink   fn_tx [N],
    tlp_stream_if.source fn_rx [N],
    tlp_stream_if.source host_tx,
    tlp_stream_if.sink   host_rx
);

    localparam int PTR_W  = (N > 1) ? $clog2(N) : 1;
    localparam int FUNC_W = `FUNC_W;

    // Function streams gathered into arrays so they can be indexed
    logic [N-1:0]       tx_valid;
    logic [N-1:0]       tx_ready;
    tlp_hdr_t           tx_hdr [N];
    logic [`DATA_W-1:0] tx_data [N];
    logic [N-1:0]       rx_ready;

    logic               grant_found;
    logic [PTR_W-1:0]   grant_idx;
    logic [PTR_W-1:0]   rr_ptr;
    tlp_hdr_t           win_hdr;
    logic               load_ok;
    logic               rx_sel_ready;

    // Output slice
    logic               out_valid;
    tlp_hdr_t           out_hdr;
    logic [`DATA_W-1:0] out_data;

    for (genvar i = 0; i < N; i++)
    begin : g_port
        assign tx_valid[i]    = fn_tx[i].valid;
        assign tx_hdr[i]      = fn_tx[i].hdr;
        assign tx_data[i]     = fn_tx[i].data;
        assign fn_tx[i].ready = tx_ready[i];

        // Only the addressed function sees a valid response
        assign fn_rx[i].valid = host_rx.valid && (host_rx.hdr.func == FUNC_W'(i));
        assign fn_rx[i].hdr   = host_rx.hdr;
        assign fn_rx[i].data  = host_rx.data;
        assign rx_ready[i]    = fn_rx[i].ready;
    end

    // Search starts at the pointer and wraps, so the last winner goes to the back
    always_comb
    begin
        int unsigned idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int unsigned k = 0; k < N; k++)
        begin
            idx = (int'(rr_ptr) + k) % N;
            if (!grant_found && tx_valid[idx])
            begin
                grant_found = 1'b1;
                grant_idx   = PTR_W'(idx);
            end
        end
    end

    // The slice takes a new beat when empty or when it unloads this cycle
    assign load_ok = !out_valid || host_tx.ready;

    always_comb
    begin
        tx_ready = '0;
        tx_ready[grant_idx] = load_ok && grant_found;
    end

    // Overwrite func with the port number so responses find their way back
    always_comb
    begin
        win_hdr      = tx_hdr[grant_idx];
        win_hdr.func = FUNC_W'(grant_idx);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            rr_ptr    <= '0;
        end
        else if (load_ok && grant_found)
        begin
            out_valid <= 1'b1;
            if (grant_idx == PTR_W'(N - 1))
                rr_ptr <= '0;
            else
                rr_ptr <= grant_idx + 1'b1;
        end
        else if (host_tx.ready)
        begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_ok && grant_found)
        begin
            out_hdr  <= win_hdr;
            out_data <= tx_data[grant_idx];
        end
    end

    assign host_tx.valid = out_valid;
    assign host_tx.hdr   = out_hdr;
    assign host_tx.data  = out_data;

    // Host RX back-pressure comes from the function the beat is headed to
    always_comb
    begin
        rx_sel_ready = 1'b0;
        for (int i = 0; i < N; i++)
        begin
            if (host_rx.hdr.func == FUNC_W'(i))
                rx_sel_ready = rx_ready[i];
        end
    end

    assign host_rx.ready = rx_sel_ready;

endmodule

// File: src/tlp_ab_arbiter.sv
/*
 * Merges the host-bound A and B TX streams into one stream.
 * Priority alternates after every grant and the winner is registered.
 */

`include "host_chan_settings.svh"

module tlp_ab_arbiter
    import host_chan_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    tlp_stream_if.sink   in_a,
    tlp_stream_if.sink   in_b,
    tlp_stream_if.source out
);

    logic               prio_b;
    logic               grant_a;
    logic               grant_b;
    logic               load_ok;
    logic               out_valid;
    tlp_hdr_t           out_hdr;
    logic [`DATA_W-1:0] out_data;

    // A wins when it is alone or when B does not hold priority
    assign grant_a = in_a.valid && (!in_b.valid || !prio_b);
    assign grant_b = in_b.valid && (!in_a.valid || prio_b);

    // Same slice rule as the mux, load while empty or unloading
    assign load_ok = !out_valid || out.ready;

    assign in_a.ready = load_ok && grant_a;
    assign in_b.ready = load_ok && grant_b;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            prio_b    <= 1'b0;
        end
        else if (load_ok && (grant_a || grant_b))
        begin
            out_valid <= 1'b1;
            // Hand priority to the side that just lost
            prio_b    <= grant_a;
        end
        else if (out.ready)
        begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_ok && (grant_a || grant_b))
        begin
            out_hdr  <= grant_a ? in_a.hdr : in_b.hdr;
            out_data <= grant_a ? in_a.data : in_b.data;
        end
    end

    assign out.valid = out_valid;
    assign out.hdr   = out_hdr;
    assign out.data  = out_data;

endmodule

// File: src/tlp_stream_if.sv
/*
 * Valid/ready stream carrying one TLP header and one data word per beat.
 * The source drives valid and payload, the sink drives ready.
 */

`include "host_chan_settings.svh"

interface tlp_stream_if
    import host_chan_pkg::*;
();

    logic               valid;
    logic               ready;
    tlp_hdr_t           hdr;
    logic [`DATA_W-1:0] data;

    // Producer side of the stream
    modport source
    (
        output valid,
        output hdr,
        output data,
        input  ready
    );

    // Consumer side of the stream
    modport sink
    (
        input  valid,
        input  hdr,
        input  data,
        output ready
    );

endinterface
